// File: include/mtt_settings.svh
/*
 * MTT lookup settings
 * field widths, page and cacheline geometry, output FIFO sizing
 * and segment opcodes for the read-WQE request parser
 */
`ifndef MTT_SETTINGS_SVH
`define MTT_SETTINGS_SVH

// 4 KB pages
`define MTT_PAGE_SHIFT 12
// 4 MTT entries per cacheline
`define MTT_CL_SHIFT 2
`define MTT_CL_ENTRIES 4

// packed request and segment widths
`define MTT_REQ_W 163
`define MTT_SEG_W 198

// output FIFO, afull keeps a slot for the registered write in flight
`define MTT_FIFO_DEPTH 16
`define MTT_FIFO_AFULL (`MTT_FIFO_DEPTH - 2)

// segment opcodes
`define MTT_OP_RD_FIRST 3'h2
`define MTT_OP_RD 3'h1

`endif

// File: design/mtt_pkg.sv
/*
 * MTT parser types
 * vector types for request and segment fields and the
 * splitter state encoding
 */
`default_nettype none

`include "mtt_settings.svh"

package mtt_pkg;

    // request fields
    typedef logic [2:0] src_t;
    typedef logic [63:0] mtt_index_t;
    typedef logic [63:0] vaddr_t;
    typedef logic [31:0] byte_len_t;

    // page or cacheline lookup count
    typedef logic [31:0] count_t;

    // segment opcode
    typedef logic [2:0] op_t;

    // request: src | mtt_index | vaddr | length
    typedef logic [`MTT_REQ_W-1:0] req_t;
    // segment: src | total len | op | mtt addr | seg vaddr | seg len
    typedef logic [`MTT_SEG_W-1:0] seg_t;

    // splitter FSM
    typedef enum logic {IDLE, LOOKUP} split_state_t;

endpackage

`default_nettype wire

// File: design/seg_fifo.sv
/*
 * Segment FIFO
 * synchronous circular buffer, first-word-fall-through read port,
 * programmable-full flag for upstream back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

`include "mtt_settings.svh"

module seg_fifo (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          wr_en,
    input  wire mtt_pkg::seg_t din,
    input  wire logic          rd_en,
    output mtt_pkg::seg_t      dout,
    output logic               empty,
    output logic               prog_full
);
    import mtt_pkg::*;

    localparam int DEPTH = `MTT_FIFO_DEPTH;
    localparam int AFULL = `MTT_FIFO_AFULL;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // storage, no reset needed
    seg_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_wr;
    logic             do_rd;

    // overflow and underflow attempts dropped
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head entry shown while not empty
    assign dout      = mem[rd_ptr];
    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign prog_full = (count >= CNT_W'(AFULL));

endmodule

`default_nettype wire

// File: design/span_calc.sv
/*
 * Request span calculation
 * base MTT address, touched page count and cacheline lookup
 * count for one read request, all combinational
 */
`timescale 1ns/1ps
`default_nettype none

`include "mtt_settings.svh"

module span_calc (
    input  wire mtt_pkg::req_t  req,
    output mtt_pkg::mtt_index_t base_addr,
    output mtt_pkg::count_t     page_count,
    output mtt_pkg::count_t     lookup_count
);
    import mtt_pkg::*;

    localparam int PS = `MTT_PAGE_SHIFT;
    localparam int CS = `MTT_CL_SHIFT;
    localparam int LOW_W = $bits(mtt_index_t) + $bits(vaddr_t) + $bits(byte_len_t);

    mtt_index_t  req_index;
    vaddr_t      req_vaddr;
    byte_len_t   req_len;
    logic [32:0] off_plus_len;
    logic [32:0] cl_off_plus_pages;

    // src tag not needed here
    assign {req_index, req_vaddr, req_len} = req[LOW_W-1:0];

    // mtt index plus virtual page number
    assign base_addr = req_index + mtt_index_t'(req_vaddr[63:PS]);

    // ceil((page offset + length) / page size)
    assign off_plus_len = 33'(req_vaddr[PS-1:0]) + 33'(req_len);
    assign page_count   = count_t'(off_plus_len[32:PS]) + count_t'(|off_plus_len[PS-1:0]);

    // ceil((entry offset in cacheline + pages) / entries per cacheline)
    assign cl_off_plus_pages = 33'(base_addr[CS-1:0]) + 33'(page_count);
    // a request with no pages needs no lookup
    assign lookup_count      = (page_count == '0) ? '0 :
                               count_t'(cl_off_plus_pages[32:CS])
                             + count_t'(|cl_off_plus_pages[CS-1:0]);

endmodule

`default_nettype wire

// File: design/lookup_splitter.sv
/*
 * Cacheline lookup splitter
 * pops one request, then walks it one MTT cacheline per segment,
 * tagging the first segment with the first-read opcode
 */
`timescale 1ns/1ps
`default_nettype none

`include "mtt_settings.svh"

module lookup_splitter (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire mtt_pkg::req_t       req_dout,
    input  wire logic                req_empty,
    output logic                     req_rd_en,
    output mtt_pkg::req_t            cur_req,
    input  wire mtt_pkg::mtt_index_t base_addr,
    input  wire mtt_pkg::count_t     page_count,
    input  wire mtt_pkg::count_t     lookup_count,
    input  wire logic                prog_full,
    output logic                     seg_wr_en,
    output mtt_pkg::seg_t            seg_din
);
    import mtt_pkg::*;

    localparam int PS = `MTT_PAGE_SHIFT;
    localparam int CS = `MTT_CL_SHIFT;
    localparam int SRC_W = $bits(src_t);
    localparam int LEN_W = $bits(byte_len_t);
    localparam int VL_W = $bits(vaddr_t) + LEN_W;
    localparam count_t CL_ENTRIES = `MTT_CL_ENTRIES;
    localparam byte_len_t PAGE_BYTES = byte_len_t'(1) << PS;

    split_state_t state;
    split_state_t state_nxt;

    // held request and walk registers
    req_t       held_req;
    count_t     seg_cnt;
    mtt_index_t mtt_addr;
    count_t     left_entries;
    vaddr_t     cur_vaddr;
    byte_len_t  left_bytes;

    vaddr_t     in_vaddr;
    byte_len_t  in_len;
    src_t       held_src;
    byte_len_t  held_len;
    logic       issue;
    logic       done;
    logic       crosses;
    count_t     cl_off;
    count_t     entries_in_cl;
    byte_len_t  seg_len;
    op_t        seg_op;

    // ------------------------------------------------------------------
    // request acceptance
    // ------------------------------------------------------------------
    assign req_rd_en = (state == IDLE) && !req_empty && !prog_full;
    // span_calc follows the live head until a request is held
    assign cur_req   = (state == IDLE) ? req_dout : held_req;

    assign {in_vaddr, in_len} = req_dout[VL_W-1:0];
    assign held_src = held_req[$bits(req_t)-1 -: SRC_W];
    assign held_len = held_req[LEN_W-1:0];

    // ------------------------------------------------------------------
    // segment decision
    // ------------------------------------------------------------------
    assign issue = (state == LOOKUP) && !prog_full && (left_entries != '0)
                && (seg_cnt < lookup_count);
    // every lookup issued
    assign done  = (state == LOOKUP) && (seg_cnt == lookup_count);

    assign cl_off        = count_t'(mtt_addr[CS-1:0]);
    assign entries_in_cl = CL_ENTRIES - cl_off;
    // remaining entries run past this cacheline
    assign crosses       = (cl_off + left_entries) > CL_ENTRIES;

    // rest of current page plus the full pages up to cacheline end
    assign seg_len = crosses ?
        (PAGE_BYTES - byte_len_t'(cur_vaddr[PS-1:0])) + ((entries_in_cl - 1'b1) << PS) :
        left_bytes;
    assign seg_op  = (seg_cnt == '0) ? `MTT_OP_RD_FIRST : `MTT_OP_RD;

    always_comb begin
        state_nxt = state;
        unique case (state)
            IDLE:    if (req_rd_en) state_nxt = LOOKUP;
            LOOKUP:  if (done) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // ------------------------------------------------------------------
    // control registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            seg_cnt      <= '0;
            left_entries <= '0;
            seg_wr_en    <= 1'b0;
        end else begin
            state     <= state_nxt;
            seg_wr_en <= issue;
            if (state == IDLE) begin
                seg_cnt <= '0;
            end else if (issue) begin
                seg_cnt <= seg_cnt + 1'b1;
            end
            if (req_rd_en) begin
                left_entries <= page_count;
            end else if (issue) begin
                left_entries <= crosses ? left_entries - entries_in_cl : '0;
            end
        end
    end

    // ------------------------------------------------------------------
    // payload registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (req_rd_en) begin
            held_req   <= req_dout;
            mtt_addr   <= base_addr;
            cur_vaddr  <= in_vaddr;
            left_bytes <= in_len;
        end else if (issue && crosses) begin
            // next aligned cacheline, page-aligned vaddr after it
            mtt_addr   <= {mtt_addr[63:CS], CS'(0)} + mtt_index_t'(CL_ENTRIES);
            cur_vaddr  <= {cur_vaddr[63:PS], PS'(0)} + (vaddr_t'(entries_in_cl) << PS);
            left_bytes <= left_bytes - seg_len;
        end else if (issue) begin
            left_bytes <= '0;
        end
        // written into the FIFO on the following edge
        if (issue) begin
            seg_din <= {held_src, held_len, seg_op, mtt_addr, cur_vaddr, seg_len};
        end
    end

endmodule

`default_nettype wire

// File: design/mpt_rd_wqe_parser.sv
/*
 * MPT read-WQE request parser
 * splits DMA read requests into per-cacheline MTT lookup
 * segments behind a buffered FWFT output port
 */
`timescale 1ns/1ps
`default_nettype none

module mpt_rd_wqe_parser (
    input  wire logic          clk,
    input  wire logic          rst,
    // upstream request FIFO
    input  wire mtt_pkg::req_t req_dout,
    input  wire logic          req_empty,
    output logic               req_rd_en,
    // downstream segment port
    output mtt_pkg::seg_t      seg_dout,
    output logic               seg_empty,
    input  wire logic          seg_rd_en
);
    import mtt_pkg::*;

    req_t       cur_req;
    mtt_index_t base_addr;
    count_t     page_count;
    count_t     lookup_count;
    logic       prog_full;
    logic       seg_wr_en;
    seg_t       seg_din;

    // span of the current request
    span_calc span_calc_i (
        .req          (cur_req),
        .base_addr    (base_addr),
        .page_count   (page_count),
        .lookup_count (lookup_count)
    );

    lookup_splitter lookup_splitter_i (
        .clk          (clk),
        .rst          (rst),
        .req_dout     (req_dout),
        .req_empty    (req_empty),
        .req_rd_en    (req_rd_en),
        .cur_req      (cur_req),
        .base_addr    (base_addr),
        .page_count   (page_count),
        .lookup_count (lookup_count),
        .prog_full    (prog_full),
        .seg_wr_en    (seg_wr_en),
        .seg_din      (seg_din)
    );

    // output buffer
    seg_fifo seg_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (seg_wr_en),
        .din       (seg_din),
        .rd_en     (seg_rd_en),
        .dout      (seg_dout),
        .empty     (seg_empty),
        .prog_full (prog_full)
    );

endmodule

`default_nettype wire

// File: verification/parser_chk.sv
/*
 * Parser protocol checker
 * concurrent assertions on the request and segment FIFO ports,
 * bound into the parser top level
 */
`timescale 1ns/1ps
`default_nettype none

module parser_chk (
    input wire logic          clk,
    input wire logic          rst,
    input wire logic          req_empty,
    input wire logic          req_rd_en,
    input wire mtt_pkg::seg_t seg_dout,
    input wire logic          seg_empty,
    input wire logic          seg_rd_en
);
    // failed assertion tally, watched from the testbench
    int fail_count = 0;

    // ------------------------------------------------------------------
    // upstream port
    // ------------------------------------------------------------------
    // no pop from an empty source
    req_pop_legal: assert property (@(posedge clk) disable iff (rst)
        req_empty |-> !req_rd_en)
    else begin
        $error("req_rd_en asserted while req_empty is high");
        fail_count = fail_count + 1;
    end

    // ------------------------------------------------------------------
    // downstream port
    // ------------------------------------------------------------------
    // head entry holds until it is read
    seg_head_stable: assert property (@(posedge clk) disable iff (rst)
        (!seg_empty && !seg_rd_en) |=> $stable(seg_dout))
    else begin
        $error("seg_dout changed while a segment was waiting unread");
        fail_count = fail_count + 1;
    end

    // output FIFO comes out of reset empty
    seg_empty_after_rst: assert property (@(posedge clk)
        $fell(rst) |-> seg_empty)
    else begin
        $error("seg_empty low in the first cycle after reset");
        fail_count = fail_count + 1;
    end

endmodule

bind mpt_rd_wqe_parser parser_chk parser_chk_i (
    .clk       (clk),
    .rst       (rst),
    .req_empty (req_empty),
    .req_rd_en (req_rd_en),
    .seg_dout  (seg_dout),
    .seg_empty (seg_empty),
    .seg_rd_en (seg_rd_en)
);

`default_nettype wire

// File: verification/parser_tb.sv
/*
 * Read-WQE parser testbench
 * directed and random DMA read requests from a FWFT source,
 * segment reference model, stalling consumer and watchdog
 */
`timescale 1ns/1ps
`default_nettype none

`include "mtt_settings.svh"

module parser_tb;
    import mtt_pkg::*;

    localparam int N_DIRECTED = 6;
    localparam int N_RANDOM = 40;
    // long consumer stall starts after this many reads
    localparam int STALL_AT = 12;
    localparam int LONG_STALL = 150;
    localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * 200 + LONG_STALL;
    localparam logic [63:0] PAGE_BYTES = 64'd1 << `MTT_PAGE_SHIFT;
    localparam logic [63:0] CL = `MTT_CL_ENTRIES;

    logic clk;
    logic rst;
    req_t req_dout;
    logic req_empty;
    logic req_rd_en;
    seg_t seg_dout;
    logic seg_empty;
    logic seg_rd_en;

    // pending requests and expected segments, both in order
    req_t req_q[$];
    seg_t exp_q[$];
    int   reads;
    int   stall_left;
    logic saw_prog_full;
    logic finished;

    mpt_rd_wqe_parser mpt_rd_wqe_parser_i (
        .clk       (clk),
        .rst       (rst),
        .req_dout  (req_dout),
        .req_empty (req_empty),
        .req_rd_en (req_rd_en),
        .seg_dout  (seg_dout),
        .seg_empty (seg_empty),
        .seg_rd_en (seg_rd_en)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // failure reporting
    // ------------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        abort_run($sformatf("** Error: %s got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    // queue one request and the segments it should split into
    task automatic queue_request(input src_t src, input mtt_index_t index,
                                 input vaddr_t vaddr, input byte_len_t len);
        logic [63:0] base;
        logic [63:0] pages;
        logic [63:0] lookups;
        logic [63:0] addr;
        logic [63:0] left;
        logic [63:0] va;
        logic [63:0] bytes_left;
        logic [63:0] off;
        logic [63:0] slen;
        logic [63:0] n;
        op_t         op;
        req_q.push_back({src, index, vaddr, len});
        // mtt index plus virtual page number
        base    = index + (vaddr >> `MTT_PAGE_SHIFT);
        pages   = ((vaddr % PAGE_BYTES) + 64'(len) + PAGE_BYTES - 1) / PAGE_BYTES;
        // zero pages give zero lookups
        lookups = (pages == 0) ? 64'd0 : ((base % CL) + pages + CL - 1) / CL;
        addr       = base;
        left       = pages;
        va         = vaddr;
        bytes_left = 64'(len);
        for (n = 0; n < lookups; n = n + 1) begin
            off = addr % CL;
            op  = (n == 0) ? `MTT_OP_RD_FIRST : `MTT_OP_RD;
            if (off + left > CL) begin
                // rest of this page plus whole pages to cacheline end
                slen = PAGE_BYTES - (va % PAGE_BYTES) + (CL - 1 - off) * PAGE_BYTES;
                exp_q.push_back({src, len, op, addr, va, slen[31:0]});
                addr       = addr - off + CL;
                left       = left - (CL - off);
                va         = va - (va % PAGE_BYTES) + (CL - off) * PAGE_BYTES;
                bytes_left = bytes_left - slen;
            end else begin
                exp_q.push_back({src, len, op, addr, va, bytes_left[31:0]});
            end
        end
    endtask

    // compare a popped segment with the model, field by field
    task automatic check_segment(input seg_t got);
        seg_t       exp;
        src_t       g_src;
        src_t       e_src;
        byte_len_t  g_total;
        byte_len_t  e_total;
        op_t        g_op;
        op_t        e_op;
        mtt_index_t g_addr;
        mtt_index_t e_addr;
        vaddr_t     g_va;
        vaddr_t     e_va;
        byte_len_t  g_len;
        byte_len_t  e_len;
        if (exp_q.size() == 0) begin
            abort_run("segment arrived after every expected segment was read");
        end else begin
            exp = exp_q.pop_front();
            {g_src, g_total, g_op, g_addr, g_va, g_len} = got;
            {e_src, e_total, e_op, e_addr, e_va, e_len} = exp;
            assert (g_src == e_src) else report_mismatch("seg_dout.src", 64'(g_src), 64'(e_src));
            assert (g_total == e_total)
                else report_mismatch("seg_dout.total_len", 64'(g_total), 64'(e_total));
            assert (g_op == e_op) else report_mismatch("seg_dout.op", 64'(g_op), 64'(e_op));
            assert (g_addr == e_addr) else report_mismatch("seg_dout.mtt_addr", g_addr, e_addr);
            assert (g_va == e_va) else report_mismatch("seg_dout.vaddr", g_va, e_va);
            assert (g_len == e_len)
                else report_mismatch("seg_dout.seg_len", 64'(g_len), 64'(e_len));
        end
    endtask

    // ------------------------------------------------------------------
    // one cycle of consumer and request source, from the falling edge
    // ------------------------------------------------------------------
    task automatic drive_cycle();
        if (stall_left > 0) begin
            seg_rd_en  = 1'b0;
            stall_left = stall_left - 1;
            if (mpt_rd_wqe_parser_i.prog_full) begin
                saw_prog_full = 1'b1;
            end
        end else if (!seg_empty && (($urandom % 4) != 0)) begin
            check_segment(seg_dout);
            seg_rd_en = 1'b1;
            reads     = reads + 1;
            if (reads == STALL_AT) begin
                stall_left = LONG_STALL;
            end
        end else begin
            seg_rd_en = 1'b0;
        end
        // FWFT source shows the head
        if (req_q.size() != 0) begin
            req_empty = 1'b0;
            req_dout  = req_q[0];
        end else begin
            req_empty = 1'b1;
            req_dout  = '0;
        end
        // pop settles after the new inputs, transfer on next rising edge
        #1;
        if (req_rd_en) begin
            void'(req_q.pop_front());
        end
    endtask

    // bound checker failures end the run as well
    always @(negedge clk) begin
        if (mpt_rd_wqe_parser_i.parser_chk_i.fail_count != 0) begin
            abort_run("protocol checker assertion failed");
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        abort_run("watchdog expired before every expected segment was read");
    end

    initial begin : main
        rst           = 1'b1;
        req_empty     = 1'b1;
        req_dout      = '0;
        seg_rd_en     = 1'b0;
        reads         = 0;
        stall_left    = 0;
        saw_prog_full = 1'b0;
        finished      = 1'b0;
        void'($urandom(32'h5927));

        // single page, page-offset crossing, cacheline crossing
        queue_request(3'd1, 64'h100, 64'h2010, 32'h200);
        queue_request(3'd2, 64'h200, 64'h5f00, 32'h300);
        queue_request(3'd3, 64'h300, 64'h3800, 32'h1000);
        // long run over several cachelines
        queue_request(3'd4, 64'h1000, 64'h1_0000_0123, 32'h9000);
        // aligned zero length, then one more behind it
        queue_request(3'd5, 64'h400, 64'h7000, 32'h0);
        queue_request(3'd6, 64'h500, 64'h9abc, 32'h1800);
        for (int i = 0; i < N_RANDOM; i++) begin
            queue_request(src_t'($urandom), {$urandom, $urandom}, {$urandom, $urandom},
                          byte_len_t'($urandom % 32'd65537));
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (!finished) begin
            @(negedge clk);
            drive_cycle();
            finished = (req_q.size() == 0) && (exp_q.size() == 0) && seg_empty && !seg_rd_en;
        end
        // quiet period, any extra segment gets read and flagged
        repeat (20) begin
            @(negedge clk);
            drive_cycle();
        end
        assert (seg_empty) else abort_run("segment left in the output FIFO at end of run");

        if (saw_prog_full) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            abort_run("prog_full never asserted during the long consumer stall");
        end
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
design/mtt_pkg.sv
design/seg_fifo.sv
design/span_calc.sv
design/lookup_splitter.sv
design/mpt_rd_wqe_parser.sv
verification/parser_chk.sv
verification/parser_tb.sv

// File: Makefile
# Verilator build and run of the read-WQE parser testbench
# pass is decided by the pass line in the simulation output

VERILATOR ?= verilator
TOP       ?= parser_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /$(PASS_TEXT)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
